//--- verilog/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define ADDR_W 32
`define DATA_W 32
`define BE_W 4

// ------------------------------------------------------------
// SRAM bank and swap slot geometry
// ------------------------------------------------------------
`define BANK_WORDS 256
// Word address width of one bank
`define BANK_AW 8
// Four slots of 64 words each
`define SLOT_W 2
// Logical address bits reported to the swap controller
`define SWAP_ADDR_W 21

// ------------------------------------------------------------
// Peripherals
// ------------------------------------------------------------
`define PERIPH_SPAN 32'h0000_1000
`define GPIO_COUNT 8

// Read data of the error subordinate
`define ERR_RDATA 32'hBADCAB1E

`endif

//--- verilog/soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

  // Decoded destination of a request
  typedef enum logic [1:0] {
    TGT_SRAM     = 2'd0,
    TGT_SOC_CTRL = 2'd1,
    TGT_GPIO     = 2'd2,
    TGT_ERROR    = 2'd3
  } target_e;

  // Word offset inside a peripheral
  // SoC control: boot address, fetch enable, scratch
  // GPIO: output, output enable, input
  typedef enum logic [1:0] {
    REG_0   = 2'd0,
    REG_1   = 2'd1,
    REG_2   = 2'd2,
    REG_BAD = 2'd3
  } reg_off_e;

  // Address map
  localparam logic [`ADDR_W-1:0] SRAM_BASE     = 32'h1000_0000;
  localparam logic [`ADDR_W-1:0] SOC_CTRL_BASE = 32'h0300_0000;
  localparam logic [`ADDR_W-1:0] GPIO_BASE     = 32'h0300_5000;

  // SRAM window is one bank wide
  function automatic logic is_sram_addr(input logic [`ADDR_W-1:0] addr);
    return addr[`ADDR_W-1:`BANK_AW+2] == SRAM_BASE[`ADDR_W-1:`BANK_AW+2];
  endfunction

endpackage

//--- verilog/req_blocker.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module req_blocker import soc_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // Manager side
  input  logic                    req_i,
  input  logic [`ADDR_W-1:0]      addr_i,
  output logic                    gnt_o,

  // Toward the router
  output logic                    req_o,
  output logic [`ADDR_W-1:0]      addr_o,
  input  logic                    gnt_i,

  // Swap controller
  output logic [`SWAP_ADDR_W-1:0] req_addr_o,
  output logic                    valid_o,
  input  logic [`SLOT_W-1:0]      sram_addr_idx_i,
  input  logic                    block_i
);

  logic in_sram;

  assign in_sram = is_sram_addr(addr_i);

  // ------------------------------------------------------------
  // Swap controller report
  // ------------------------------------------------------------
  // Reported even while blocked so the controller can finish its swap
  assign valid_o    = req_i & in_sram;
  assign req_addr_o = addr_i[`SWAP_ADDR_W-1:0];

  // ------------------------------------------------------------
  // Address remap
  // ------------------------------------------------------------
  // Physical slot replaces the top word address bits of the bank
  always_comb begin
    addr_o = addr_i;
    if (in_sram) begin
      addr_o = {addr_i[`ADDR_W-1:`BANK_AW+2],
                sram_addr_idx_i,
                addr_i[`BANK_AW+1-`SLOT_W:0]};
    end
  end

  // Stall both directions while a swap is running
  assign req_o = req_i & ~block_i;
  assign gnt_o = gnt_i & ~block_i;

  // A grant answers a live request and never comes during a swap
  a_no_gnt_when_blocked: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    gnt_o |-> req_i && !block_i
  );

endmodule

//--- verilog/bus_router.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module bus_router import soc_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,

  // Manager side
  input  logic                req_i,
  input  logic [`ADDR_W-1:0]  addr_i,
  input  logic                we_i,
  input  logic [`BE_W-1:0]    be_i,
  input  logic [`DATA_W-1:0]  wdata_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output logic [`DATA_W-1:0]  rdata_o,
  output logic                err_o,

  // SRAM bank
  output logic                mem_req_o,
  output logic                mem_we_o,
  output logic [`BANK_AW-1:0] mem_addr_o,
  output logic [`BE_W-1:0]    mem_be_o,
  output logic [`DATA_W-1:0]  mem_wdata_o,
  input  logic [`DATA_W-1:0]  mem_rdata_i,

  // Register peripherals
  output logic                ctrl_req_o,
  output logic                gpio_req_o,
  output logic                per_we_o,
  output reg_off_e            per_off_o,
  output logic [`DATA_W-1:0]  per_wdata_o,
  input  logic [`DATA_W-1:0]  ctrl_rdata_i,
  input  logic                ctrl_err_i,
  input  logic [`DATA_W-1:0]  gpio_rdata_i,
  input  logic                gpio_err_i
);

  target_e tgt, tgt_q;
  logic    accept;
  logic    we_q;

  function automatic target_e decode_target(input logic [`ADDR_W-1:0] addr);
    if (is_sram_addr(addr)) begin
      return TGT_SRAM;
    end
    if (addr - SOC_CTRL_BASE < `PERIPH_SPAN) begin
      return TGT_SOC_CTRL;
    end
    if (addr - GPIO_BASE < `PERIPH_SPAN) begin
      return TGT_GPIO;
    end
    return TGT_ERROR;
  endfunction

  // ------------------------------------------------------------
  // Address phase
  // ------------------------------------------------------------
  assign tgt = decode_target(addr_i);

  // Every target answers in one cycle, so the router never stalls
  assign gnt_o  = req_i;
  assign accept = req_i & gnt_o;

  assign mem_req_o   = accept & (tgt == TGT_SRAM);
  assign mem_we_o    = we_i;
  assign mem_addr_o  = addr_i[`BANK_AW+1:2];
  assign mem_be_o    = be_i;
  assign mem_wdata_o = wdata_i;

  assign ctrl_req_o  = accept & (tgt == TGT_SOC_CTRL);
  assign gpio_req_o  = accept & (tgt == TGT_GPIO);
  assign per_we_o    = we_i;
  assign per_wdata_o = wdata_i;

  // Only the first three words of a peripheral exist
  always_comb begin
    per_off_o = REG_BAD;
    if (addr_i[11:4] == '0) begin
      per_off_o = reg_off_e'(addr_i[3:2]);
    end
  end

  // ------------------------------------------------------------
  // Response phase
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
      tgt_q    <= TGT_ERROR;
      we_q     <= 1'b0;
    end else begin
      rvalid_o <= accept;
      if (accept) begin
        tgt_q <= tgt;
        we_q  <= we_i;
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    err_o   = 1'b0;
    case (tgt_q)
      TGT_SRAM:     rdata_o = mem_rdata_i;
      TGT_SOC_CTRL: begin
        rdata_o = ctrl_rdata_i;
        err_o   = ctrl_err_i;
      end
      TGT_GPIO: begin
        rdata_o = gpio_rdata_i;
        err_o   = gpio_err_i;
      end
      default: begin
        // Error subordinate
        rdata_o = `ERR_RDATA;
        err_o   = 1'b1;
      end
    endcase
    // Writes return zero data except from the error subordinate
    if (we_q && tgt_q != TGT_ERROR) begin
      rdata_o = '0;
    end
    if (!rvalid_o) begin
      err_o = 1'b0;
    end
  end

  a_one_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({mem_req_o, ctrl_req_o, gpio_req_o})
  );

  a_rvalid_after_accept: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    accept |=> rvalid_o
  );

endmodule

//--- verilog/sram_bank.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module sram_bank (
  input  logic                clk_i,
  input  logic                req_i,
  input  logic                we_i,
  input  logic [`BANK_AW-1:0] addr_i,
  input  logic [`BE_W-1:0]    be_i,
  input  logic [`DATA_W-1:0]  wdata_i,
  output logic [`DATA_W-1:0]  rdata_o
);

  logic [`DATA_W-1:0] mem [`BANK_WORDS];
  logic [`DATA_W-1:0] rdata_q;

  // ------------------------------------------------------------
  // Byte-enabled write
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < `BE_W; b++) begin
        if (be_i[b]) begin
          mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Registered read, data valid one cycle after the request
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- verilog/soc_ctrl_regs.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_ctrl_regs import soc_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,

  // Register access
  input  logic               req_i,
  input  logic               we_i,
  input  reg_off_e           off_i,
  input  logic [`DATA_W-1:0] wdata_i,
  output logic [`DATA_W-1:0] rdata_o,
  output logic               err_o,

  // Core control
  input  logic               fetch_en_i,
  output logic [`ADDR_W-1:0] boot_addr_o,
  output logic               fetch_enable_o
);

  logic [`ADDR_W-1:0] boot_addr_q;
  logic               fetch_en_q;
  logic [`DATA_W-1:0] scratch_q;
  logic [`DATA_W-1:0] rdata_d;

  // Read mux
  always_comb begin
    case (off_i)
      REG_0:   rdata_d = boot_addr_q;
      REG_1:   rdata_d = {{(`DATA_W-1){1'b0}}, fetch_en_q};
      REG_2:   rdata_d = scratch_q;
      default: rdata_d = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Registers and response
  // ------------------------------------------------------------
  // Full-word writes only
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= SRAM_BASE;
      fetch_en_q  <= 1'b0;
      scratch_q   <= '0;
      rdata_o     <= '0;
      err_o       <= 1'b0;
    end else begin
      if (req_i && we_i) begin
        case (off_i)
          REG_0:   boot_addr_q <= wdata_i;
          REG_1:   fetch_en_q  <= wdata_i[0];
          REG_2:   scratch_q   <= wdata_i;
          default: ;
        endcase
      end
      if (req_i) begin
        rdata_o <= rdata_d;
        err_o   <= (off_i == REG_BAD);
      end
    end
  end

  assign boot_addr_o    = boot_addr_q;
  // Pin can start the core without software
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

//--- verilog/gpio_regs.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module gpio_regs import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // Register access
  input  logic                   req_i,
  input  logic                   we_i,
  input  reg_off_e               off_i,
  input  logic [`DATA_W-1:0]     wdata_i,
  output logic [`DATA_W-1:0]     rdata_o,
  output logic                   err_o,

  // Pins
  input  logic [`GPIO_COUNT-1:0] gpio_i,
  output logic [`GPIO_COUNT-1:0] gpio_o,
  output logic [`GPIO_COUNT-1:0] gpio_out_en_o
);

  logic [`GPIO_COUNT-1:0] out_q;
  logic [`GPIO_COUNT-1:0] oe_q;
  logic [`GPIO_COUNT-1:0] sync1_q, sync2_q;
  logic [`GPIO_COUNT-1:0] rd_bits;

  always_comb begin
    case (off_i)
      REG_0:   rd_bits = out_q;
      REG_1:   rd_bits = oe_q;
      REG_2:   rd_bits = sync2_q;
      default: rd_bits = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Registers, input synchronizer and response
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      rdata_o <= '0;
      err_o   <= 1'b0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      // Input register is read only, writes to it are dropped
      if (req_i && we_i && off_i == REG_0) begin
        out_q <= wdata_i[`GPIO_COUNT-1:0];
      end
      if (req_i && we_i && off_i == REG_1) begin
        oe_q <= wdata_i[`GPIO_COUNT-1:0];
      end
      if (req_i) begin
        rdata_o <= {{(`DATA_W-`GPIO_COUNT){1'b0}}, rd_bits};
        err_o   <= (off_i == REG_BAD);
      end
    end
  end

  assign gpio_o        = out_q;
  assign gpio_out_en_o = oe_q;

endmodule

//--- verilog/soc_domain.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_domain import soc_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    fetch_en_i,

  // Data bus manager port
  input  logic                    obi_req_i,
  input  logic [`ADDR_W-1:0]      obi_addr_i,
  input  logic                    obi_we_i,
  input  logic [`BE_W-1:0]        obi_be_i,
  input  logic [`DATA_W-1:0]      obi_wdata_i,
  output logic                    obi_gnt_o,
  output logic                    obi_rvalid_o,
  output logic [`DATA_W-1:0]      obi_rdata_o,
  output logic                    obi_err_o,

  // GPIO pins
  input  logic [`GPIO_COUNT-1:0]  gpio_i,
  output logic [`GPIO_COUNT-1:0]  gpio_o,
  output logic [`GPIO_COUNT-1:0]  gpio_out_en_o,

  // Core control
  output logic [`ADDR_W-1:0]      boot_addr_o,
  output logic                    fetch_enable_o,

  // Block swap
  output logic [`SWAP_ADDR_W-1:0] req_addr_o,
  output logic                    valid_o,
  input  logic [`SLOT_W-1:0]      sram_addr_idx_i,
  input  logic                    block_i
);

  // ------------------------------------------------------------
  // Internal buses
  // ------------------------------------------------------------
  // Blocker to router
  logic               rt_req, rt_gnt;
  logic [`ADDR_W-1:0] rt_addr;

  // Router to SRAM
  logic                mem_req, mem_we;
  logic [`BANK_AW-1:0] mem_addr;
  logic [`BE_W-1:0]    mem_be;
  logic [`DATA_W-1:0]  mem_wdata, mem_rdata;

  // Router to peripherals
  logic               ctrl_req, gpio_req, per_we;
  reg_off_e           per_off;
  logic [`DATA_W-1:0] per_wdata;
  logic [`DATA_W-1:0] ctrl_rdata, gpio_rdata;
  logic               ctrl_err, gpio_err;

  req_blocker i_req_blocker (
    .clk_i,
    .rst_n_i,
    .req_i           ( obi_req_i  ),
    .addr_i          ( obi_addr_i ),
    .gnt_o           ( obi_gnt_o  ),
    .req_o           ( rt_req     ),
    .addr_o          ( rt_addr    ),
    .gnt_i           ( rt_gnt     ),
    .req_addr_o,
    .valid_o,
    .sram_addr_idx_i,
    .block_i
  );

  bus_router i_bus_router (
    .clk_i,
    .rst_n_i,
    .req_i        ( rt_req       ),
    .addr_i       ( rt_addr      ),
    .we_i         ( obi_we_i     ),
    .be_i         ( obi_be_i     ),
    .wdata_i      ( obi_wdata_i  ),
    .gnt_o        ( rt_gnt       ),
    .rvalid_o     ( obi_rvalid_o ),
    .rdata_o      ( obi_rdata_o  ),
    .err_o        ( obi_err_o    ),
    .mem_req_o    ( mem_req      ),
    .mem_we_o     ( mem_we       ),
    .mem_addr_o   ( mem_addr     ),
    .mem_be_o     ( mem_be       ),
    .mem_wdata_o  ( mem_wdata    ),
    .mem_rdata_i  ( mem_rdata    ),
    .ctrl_req_o   ( ctrl_req     ),
    .gpio_req_o   ( gpio_req     ),
    .per_we_o     ( per_we       ),
    .per_off_o    ( per_off      ),
    .per_wdata_o  ( per_wdata    ),
    .ctrl_rdata_i ( ctrl_rdata   ),
    .ctrl_err_i   ( ctrl_err     ),
    .gpio_rdata_i ( gpio_rdata   ),
    .gpio_err_i   ( gpio_err     )
  );

  sram_bank i_sram_bank (
    .clk_i,
    .req_i   ( mem_req   ),
    .we_i    ( mem_we    ),
    .addr_i  ( mem_addr  ),
    .be_i    ( mem_be    ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .rst_n_i,
    .req_i   ( ctrl_req   ),
    .we_i    ( per_we     ),
    .off_i   ( per_off    ),
    .wdata_i ( per_wdata  ),
    .rdata_o ( ctrl_rdata ),
    .err_o   ( ctrl_err   ),
    .fetch_en_i,
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio_regs i_gpio (
    .clk_i,
    .rst_n_i,
    .req_i   ( gpio_req   ),
    .we_i    ( per_we     ),
    .off_i   ( per_off    ),
    .wdata_i ( per_wdata  ),
    .rdata_o ( gpio_rdata ),
    .err_o   ( gpio_err   ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o
  );

endmodule

//--- tb/tb_soc_domain.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc_domain import soc_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 50;
  localparam int POLL_LIMIT     = 8;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    fetch_en_i;
  logic                    obi_req_i;
  logic [`ADDR_W-1:0]      obi_addr_i;
  logic                    obi_we_i;
  logic [`BE_W-1:0]        obi_be_i;
  logic [`DATA_W-1:0]      obi_wdata_i;
  logic                    obi_gnt_o;
  logic                    obi_rvalid_o;
  logic [`DATA_W-1:0]      obi_rdata_o;
  logic                    obi_err_o;
  logic [`GPIO_COUNT-1:0]  gpio_i;
  logic [`GPIO_COUNT-1:0]  gpio_o;
  logic [`GPIO_COUNT-1:0]  gpio_out_en_o;
  logic [`ADDR_W-1:0]      boot_addr_o;
  logic                    fetch_enable_o;
  logic [`SWAP_ADDR_W-1:0] req_addr_o;
  logic                    valid_o;
  logic [`SLOT_W-1:0]      sram_addr_idx_i;
  logic                    block_i;

  logic               flip_mode;
  integer             seed;
  logic [`DATA_W-1:0] exp_mem [`BANK_WORDS];

  soc_domain UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Swap controller model, identity or flipped slots
  assign sram_addr_idx_i = flip_mode ? (req_addr_o[9:8] ^ 2'b11) : req_addr_o[9:8];

  // ------------------------------------------------------------
  // Reference model helpers
  // ------------------------------------------------------------
  function automatic logic in_sram(input logic [`ADDR_W-1:0] addr);
    return addr[31:10] == SRAM_BASE[31:10];
  endfunction

  // Physical word: returned slot, then logical bits 7..2
  function automatic logic [`BANK_AW-1:0] phys_word(input logic [`ADDR_W-1:0] addr);
    logic [`SLOT_W-1:0] slot;
    slot = flip_mode ? (addr[9:8] ^ 2'b11) : addr[9:8];
    return {slot, addr[7:2]};
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_stop($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_target_gpio(input string name, input logic [`GPIO_COUNT-1:0] got,
                                   input logic [`GPIO_COUNT-1:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_boot(input string name, input logic [`ADDR_W-1:0] got,
                            input logic [`ADDR_W-1:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // Bus tasks
  // ------------------------------------------------------------
  task automatic drive_req(input logic we, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    obi_req_i   = 1'b1;
    obi_we_i    = we;
    obi_addr_i  = addr;
    obi_be_i    = be;
    obi_wdata_i = wdata;
  endtask

  // Grant, swap report, then the response one cycle later
  task automatic complete_access(input logic [31:0] addr, output logic [31:0] rdata,
                                 output logic err);
    int cnt;
    cnt = 0;
    #1;
    while (!obi_gnt_o) begin
      cnt++;
      if (cnt >= TIMEOUT_CYCLES) fail_stop("timeout while waiting for the bus grant");
      @(negedge clk_i);
      #1;
    end
    check_err("valid_o", valid_o, in_sram(addr));
    if (in_sram(addr)) begin
      check_word("req_addr_o", 32'(req_addr_o), 32'(addr[`SWAP_ADDR_W-1:0]));
    end
    @(posedge clk_i);
    @(negedge clk_i);
    obi_req_i = 1'b0;
    cnt = 0;
    while (!obi_rvalid_o) begin
      cnt++;
      if (cnt >= TIMEOUT_CYCLES) fail_stop("timeout while waiting for the bus response");
      @(negedge clk_i);
    end
    if (cnt != 0) fail_stop("response came later than one cycle after acceptance");
    rdata = obi_rdata_o;
    err   = obi_err_o;
  endtask

  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk_i);
    drive_req(we, addr, be, wdata);
    complete_access(addr, rdata, err);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] be, input logic [31:0] wdata,
                           input logic [31:0] exp_rdata, input logic exp_err);
    logic [31:0] rd;
    logic        er;
    bus_access(1'b1, addr, be, wdata, rd, er);
    check_word("obi_rdata_o", rd, exp_rdata);
    check_err("obi_err_o", er, exp_err);
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp_rdata,
                          input logic exp_err);
    logic [31:0] rd;
    logic        er;
    bus_access(1'b0, addr, 4'hF, 32'h0, rd, er);
    check_word("obi_rdata_o", rd, exp_rdata);
    check_err("obi_err_o", er, exp_err);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_sram_remap;
    logic [31:0]         addr;
    logic [31:0]         data;
    logic [`BANK_AW-1:0] idx;
    for (int w = 0; w < 4; w++) begin
      addr = SRAM_BASE + w * 4;
      data = $random(seed);
      bus_write(addr, 4'hF, data, 32'h0, 1'b0);
      exp_mem[phys_word(addr)] = data;
      addr = SRAM_BASE + 32'h300 + w * 4;
      data = $random(seed);
      bus_write(addr, 4'hF, data, 32'h0, 1'b0);
      exp_mem[phys_word(addr)] = data;
    end
    // Partial write, bytes 0 and 2 only
    addr = SRAM_BASE + 32'h304;
    data = $random(seed);
    bus_write(addr, 4'b0101, data, 32'h0, 1'b0);
    idx = phys_word(addr);
    for (int b = 0; b < 4; b++) begin
      if (b % 2 == 0) exp_mem[idx][b*8 +: 8] = data[b*8 +: 8];
    end
    for (int w = 0; w < 4; w++) begin
      bus_read(SRAM_BASE + w * 4, exp_mem[phys_word(SRAM_BASE + w * 4)], 1'b0);
      addr = SRAM_BASE + 32'h300 + w * 4;
      bus_read(addr, exp_mem[phys_word(addr)], 1'b0);
    end
    // Flipped slots, logical slot 3 lands on slot 0
    @(negedge clk_i);
    flip_mode = 1'b1;
    for (int w = 0; w < 4; w++) begin
      bus_read(SRAM_BASE + 32'h300 + w * 4, exp_mem[w], 1'b0);
    end
  endtask

  task automatic test_pipeline;
    logic [31:0] addrs [4];
    logic [31:0] exp_q [$];
    addrs[0] = SRAM_BASE;
    addrs[1] = SRAM_BASE + 32'h300;
    addrs[2] = SRAM_BASE + 32'h004;
    addrs[3] = SRAM_BASE + 32'h304;
    for (int i = 0; i <= 4; i++) begin
      @(negedge clk_i);
      if (i > 0) begin
        check_err("obi_rvalid_o", obi_rvalid_o, 1'b1);
        check_word("obi_rdata_o", obi_rdata_o, exp_q.pop_front());
      end
      if (i < 4) begin
        drive_req(1'b0, addrs[i], 4'hF, 32'h0);
        exp_q.push_back(exp_mem[phys_word(addrs[i])]);
        #1;
        check_err("obi_gnt_o", obi_gnt_o, 1'b1);
      end else begin
        obi_req_i = 1'b0;
      end
    end
  endtask

  task automatic test_backpressure;
    logic [31:0] addr;
    logic [31:0] rd;
    logic        er;
    addr = SRAM_BASE + 32'h300;
    @(negedge clk_i);
    flip_mode = 1'b0;
    block_i   = 1'b1;
    drive_req(1'b0, addr, 4'hF, 32'h0);
    repeat (10) begin
      #1;
      check_err("obi_gnt_o", obi_gnt_o, 1'b0);
      check_err("obi_rvalid_o", obi_rvalid_o, 1'b0);
      @(negedge clk_i);
    end
    block_i = 1'b0;
    complete_access(addr, rd, er);
    check_word("obi_rdata_o", rd, exp_mem[phys_word(addr)]);
    check_err("obi_err_o", er, 1'b0);
  endtask

  task automatic test_soc_ctrl;
    logic [31:0] data;
    bus_read(SOC_CTRL_BASE, SRAM_BASE, 1'b0);
    bus_write(SOC_CTRL_BASE, 4'hF, SRAM_BASE + 32'h80, 32'h0, 1'b0);
    check_boot("boot_addr_o", boot_addr_o, SRAM_BASE + 32'h80);
    bus_read(SOC_CTRL_BASE, SRAM_BASE + 32'h80, 1'b0);
    // Pin alone, then register bit alone
    @(negedge clk_i);
    fetch_en_i = 1'b1;
    #1;
    check_err("fetch_enable_o", fetch_enable_o, 1'b1);
    @(negedge clk_i);
    fetch_en_i = 1'b0;
    #1;
    check_err("fetch_enable_o", fetch_enable_o, 1'b0);
    bus_write(SOC_CTRL_BASE + 32'h4, 4'hF, 32'h1, 32'h0, 1'b0);
    check_err("fetch_enable_o", fetch_enable_o, 1'b1);
    bus_read(SOC_CTRL_BASE + 32'h4, 32'h1, 1'b0);
    bus_write(SOC_CTRL_BASE + 32'h4, 4'hF, 32'h0, 32'h0, 1'b0);
    check_err("fetch_enable_o", fetch_enable_o, 1'b0);
    // Scratch ignores byte enables
    data = $random(seed);
    bus_write(SOC_CTRL_BASE + 32'h8, 4'h3, data, 32'h0, 1'b0);
    bus_read(SOC_CTRL_BASE + 32'h8, data, 1'b0);
    bus_read(SOC_CTRL_BASE + 32'hC, 32'h0, 1'b1);
    bus_write(SOC_CTRL_BASE + 32'hC, 4'hF, data, 32'h0, 1'b1);
  endtask

  task automatic test_gpio;
    logic [31:0] rd;
    logic        er;
    int          cnt;
    bus_write(GPIO_BASE, 4'hF, 32'hA5, 32'h0, 1'b0);
    check_target_gpio("gpio_o", gpio_o, 8'hA5);
    bus_write(GPIO_BASE + 32'h4, 4'hF, 32'h3C, 32'h0, 1'b0);
    check_target_gpio("gpio_out_en_o", gpio_out_en_o, 8'h3C);
    bus_read(GPIO_BASE, 32'hA5, 1'b0);
    bus_read(GPIO_BASE + 32'h4, 32'h3C, 1'b0);
    @(negedge clk_i);
    gpio_i = 8'h5A;
    cnt = 0;
    rd  = 32'h0;
    while (rd[7:0] != 8'h5A) begin
      if (cnt >= POLL_LIMIT) fail_stop("gpio input value never reached the input register");
      bus_access(1'b0, GPIO_BASE + 32'h8, 4'hF, 32'h0, rd, er);
      cnt++;
    end
    check_word("obi_rdata_o", rd, 32'h5A);
    check_err("obi_err_o", er, 1'b0);
    // Input register is read only
    bus_write(GPIO_BASE + 32'h8, 4'hF, 32'hFF, 32'h0, 1'b0);
    bus_read(GPIO_BASE + 32'h8, 32'h5A, 1'b0);
    bus_read(GPIO_BASE + 32'hC, 32'h0, 1'b1);
  endtask

  task automatic test_error_region;
    bus_read(32'h2000_0000, `ERR_RDATA, 1'b1);
    bus_write(32'h2000_0040, 4'hF, $random(seed), `ERR_RDATA, 1'b1);
    bus_read(32'h0300_2000, `ERR_RDATA, 1'b1);
    // Just past the end of the bank
    bus_read(SRAM_BASE + 32'h400, `ERR_RDATA, 1'b1);
  endtask

  initial begin
    seed        = 32'h469a_1de7;
    rst_n_i     = 1'b0;
    fetch_en_i  = 1'b0;
    obi_req_i   = 1'b0;
    obi_addr_i  = '0;
    obi_we_i    = 1'b0;
    obi_be_i    = '0;
    obi_wdata_i = '0;
    gpio_i      = '0;
    block_i     = 1'b0;
    flip_mode   = 1'b0;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check_err("obi_rvalid_o", obi_rvalid_o, 1'b0);
    check_target_gpio("gpio_o", gpio_o, '0);
    check_target_gpio("gpio_out_en_o", gpio_out_en_o, '0);
    check_boot("boot_addr_o", boot_addr_o, SRAM_BASE);
    check_err("fetch_enable_o", fetch_enable_o, 1'b0);
    test_sram_remap();
    test_pipeline();
    test_backpressure();
    test_soc_ctrl();
    test_gpio();
    test_error_region();
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- soc_domain.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/req_blocker.sv
verilog/bus_router.sv
verilog/sram_bank.sv
verilog/soc_ctrl_regs.sv
verilog/gpio_regs.sv
verilog/soc_domain.sv
tb/tb_soc_domain.sv

//--- Makefile
# Verilator simulation of the SoC memory and peripheral domain

VERILATOR ?= verilator
TOP       ?= tb_soc_domain
FILELIST  ?= soc_domain.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator status alone is not trusted
run: compile
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "^>>> PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
